/* verilog.f */
conv_pkg.sv
cla4_block.sv
cla_adder.sv
signed_mult_pipe.sv
mac_accumulator.sv
requant_relu.sv
conv_mac_top.sv
conv_mac_checker.sv
tb_conv_mac.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_conv_mac
FLIST     = verilog.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG) || ! grep -q ">>> PASS" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* tb_conv_mac.sv */
// every loop is bounded, so a dead DUT ends the run with a timeout count instead of a hang
`timescale 1ns/1ps
`default_nettype none

module tb_conv_mac;

  localparam int SEED      = 32'h4faf;
  localparam int MAX_TRIES = 64;   // cycles a sample may wait for an enabled edge
  localparam int DRAIN_MAX = 400;  // cycles allowed for outstanding results

  logic              clk = 1'b0;
  logic              rstn;
  logic              en;
  logic              in_valid;
  logic              in_first;
  logic              in_last;
  conv_pkg::sample_t in_feat;
  conv_pkg::sample_t in_weight;
  conv_pkg::sample_t in_bias;
  logic              out_valid;
  conv_pkg::act_t    out_act;

  int test_id;
  int mismatches;
  int protocol_errs;
  int pending;
  int timeouts;

  always #5 clk = ~clk;

  conv_mac_top dut (
    .clk       (clk),
    .rstn      (rstn),
    .en        (en),
    .in_valid  (in_valid),
    .in_first  (in_first),
    .in_last   (in_last),
    .in_feat   (in_feat),
    .in_weight (in_weight),
    .in_bias   (in_bias),
    .out_valid (out_valid),
    .out_act   (out_act)
  );

  conv_mac_checker u_chk (
    .clk           (clk),
    .rstn          (rstn),
    .en            (en),
    .in_valid      (in_valid),
    .in_first      (in_first),
    .in_last       (in_last),
    .in_feat       (in_feat),
    .in_weight     (in_weight),
    .in_bias       (in_bias),
    .out_valid     (out_valid),
    .out_act       (out_act),
    .test_id       (test_id),
    .mismatches    (mismatches),
    .protocol_errs (protocol_errs),
    .pending       (pending)
  );

  function automatic int rand_val(input int range);
    return int'($urandom % (2 * range)) - range;  // -range .. range-1
  endfunction

  ////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////
  task automatic drive_sample(input int feat, input int wgt, input int bias,
                              input bit first, input bit last, input bit stall);
    bit en_v;
    int tries;
    en_v      = stall ? ($urandom % 4 != 0) : 1'b1;
    tries     = 0;
    en        <= en_v;
    in_valid  <= 1'b1;
    in_first  <= first;
    in_last   <= last;
    in_feat   <= conv_pkg::sample_t'(feat);
    in_weight <= conv_pkg::sample_t'(wgt);
    in_bias   <= conv_pkg::sample_t'(bias);
    @(posedge clk);
    while (!en_v && tries < MAX_TRIES) begin  // sample held until an enabled edge takes it
      en_v = ($urandom % 4 != 0);
      en <= en_v;
      tries++;
      @(posedge clk);
    end
    if (!en_v) begin
      timeouts++;
      $display("timeout: a sample was not accepted within %0d cycles", MAX_TRIES);
    end
    in_valid <= 1'b0;
  endtask

  task automatic idle(input int n, input bit stall);
    for (int i = 0; i < n; i++) begin
      en       <= stall ? ($urandom % 4 != 0) : 1'b1;
      in_valid <= 1'b0;
      @(posedge clk);
    end
  endtask

  task automatic send_window(input int feats[$], input int wgts[$], input int bias,
                             input bit stall);
    int b;
    for (int i = 0; i < feats.size(); i++) begin
      if (stall && ($urandom % 3 == 0)) idle(1 + $urandom % 3, 1'b1);  // in_valid gap
      b = (i == 0) ? bias : rand_val(128);  // junk bias off the first sample
      drive_sample(feats[i], wgts[i], b, i == 0, i == feats.size() - 1, stall);
    end
  endtask

  task automatic random_window(input int len, input int range, input bit stall);
    int f[$];
    int w[$];
    for (int i = 0; i < len; i++) begin
      f.push_back(rand_val(128));
      w.push_back(rand_val(range));
    end
    send_window(f, w, rand_val(range), stall);
  endtask

  task automatic drain();
    int waited;
    waited   = 0;
    en       <= 1'b1;
    in_valid <= 1'b0;
    @(posedge clk);
    while (pending != 0 && waited < DRAIN_MAX) begin
      @(posedge clk);
      waited++;
    end
    if (pending != 0) begin
      timeouts++;
      $display("timeout: %0d results still outstanding after %0d cycles", pending, DRAIN_MAX);
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin
    int f[$];
    int w[$];
    int missing;
    void'($urandom(SEED));
    rstn      = 1'b0;
    en        = 1'b1;
    in_valid  = 1'b0;
    in_first  = 1'b0;
    in_last   = 1'b0;
    in_feat   = '0;
    in_weight = '0;
    in_bias   = '0;
    test_id   = 0;
    timeouts  = 0;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;

    test_id <= 1;  // quiet pipe, then a lone sample with en high
    idle(20, 1'b0);
    f = '{5};
    w = '{7};
    send_window(f, w, 3, 1'b0);
    drain();

    test_id <= 2;  // back to back 3x3 windows
    for (int n = 0; n < 12; n++) random_window(9, 2 << (($urandom % 3) * 3), 1'b0);
    f = '{-128, -128, -128, -128, -128, -128, -128, -128, -128};
    w = '{-128, -128, -128, -128, -128, -128, -128, -128, -128};
    send_window(f, w, -128, 1'b0);
    w = '{127, 127, 127, 127, 127, 127, 127, 127, 127};
    send_window(f, w, 127, 1'b0);
    drain();

    test_id <= 3;
    f = '{10, 20, 30};
    w = '{-5, -5, -5};
    send_window(f, w, 0, 1'b0);
    f = '{1};
    w = '{1};
    send_window(f, w, -1, 1'b0);  // -63
    f = '{0};
    send_window(f, f, -128, 1'b0);
    drain();

    test_id <= 4;  // around the 8192 limit
    f = '{-128};
    w = '{-64};
    send_window(f, w, 0, 1'b0);
    f = '{127, 8};
    w = '{64, 8};
    send_window(f, w, 0, 1'b0);
    f = '{127, 7};
    w = '{64, 9};
    send_window(f, w, 0, 1'b0);   // 8191
    f = '{127, -1};
    w = '{64, 1};
    send_window(f, w, 0, 1'b0);   // 8127
    f = '{100};
    w = '{-1};
    send_window(f, w, 127, 1'b0);
    drain();

    test_id <= 5;
    for (int n = 0; n < 20; n++) begin
      random_window(1 + $urandom % 12, 2 << (($urandom % 3) * 3), 1'b1);
      idle($urandom % 4, 1'b1);
    end
    drain();
    @(negedge clk);  // checker counts from the last rising edge have settled

    missing = pending;
    if (missing != 0) $display("%0d expected results never appeared on out_valid", missing);
    $display("summary: %0d mismatches, %0d protocol errors, %0d missing, %0d timeouts",
             mismatches, protocol_errs, missing, timeouts);
    if (mismatches + protocol_errs + missing + timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* conv_mac_checker.sv */
// watches DUT ports only; every window must open with in_first, whose sample carries the bias
`timescale 1ns/1ps
`default_nettype none

module conv_mac_checker (
  input  logic              clk,
  input  logic              rstn,
  input  logic              en,
  input  logic              in_valid,
  input  logic              in_first,
  input  logic              in_last,
  input  conv_pkg::sample_t in_feat,
  input  conv_pkg::sample_t in_weight,
  input  conv_pkg::sample_t in_bias,
  input  logic              out_valid,
  input  conv_pkg::act_t    out_act,
  input  int                test_id,
  output int                mismatches,
  output int                protocol_errs,
  output int                pending
);

  localparam int LATENCY = 10;  // enabled edges from accepting a last sample to out_valid

  int             win_feat[$];  // current window
  int             win_wgt[$];
  int             win_bias;
  conv_pkg::act_t exp_q[$];     // expected results in order
  int             tid_q[$];
  int             stamp_q[$];   // enabled edge count at the last sample
  int             en_cnt;
  int             n_mismatch;
  int             n_protocol;

  initial begin
    win_bias   = 0;
    en_cnt     = 0;
    n_mismatch = 0;
    n_protocol = 0;
  end

  function automatic string test_name(input int id);
    case (id)
      1:       return "single_sample";
      2:       return "random_windows";
      3:       return "negative_sum";
      4:       return "saturation";
      5:       return "stall_and_gaps";
      default: return "unnamed";
    endcase
  endfunction

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  // bias in accumulator scale plus all products, then relu, saturate, drop fraction
  function automatic conv_pkg::act_t ref_act(input int bias,
                                             input int feats[$],
                                             input int wgts[$]);
    int acc;
    int scale;
    int sat;
    scale = 2 ** conv_pkg::FRAC_BITS;
    sat   = (conv_pkg::OUT_MAX + 1) * scale;
    acc   = bias * scale;
    for (int i = 0; i < feats.size(); i++) acc += feats[i] * wgts[i];
    if (acc < 0) return '0;
    if (acc >= sat) return conv_pkg::act_t'(conv_pkg::OUT_MAX);
    return conv_pkg::act_t'(acc / scale);
  endfunction

  task automatic record_sample();
    conv_pkg::act_t e;
    if (in_first) begin
      win_feat.delete();
      win_wgt.delete();
      win_bias = int'(in_bias);  // bias only counts on the first sample
    end else if (win_feat.size() == 0) begin
      n_protocol++;
      $display("a sample arrived without in_first while no window was open");
    end
    win_feat.push_back(int'(in_feat));
    win_wgt.push_back(int'(in_weight));
    if (in_last) begin
      e = ref_act(win_bias, win_feat, win_wgt);
      exp_q.push_back(e);
      tid_q.push_back(test_id);
      stamp_q.push_back(en_cnt);
      win_feat.delete();
      win_wgt.delete();
    end
  endtask

  task automatic check_result();
    conv_pkg::act_t e;
    int tid;
    int lat;
    if (exp_q.size() == 0) begin
      n_protocol++;
      $display("out_valid rose with activation %0d but no window was outstanding", out_act);
    end else begin
      e   = exp_q.pop_front();
      tid = tid_q.pop_front();
      lat = en_cnt - stamp_q.pop_front() + 1;
      if (out_act !== e) begin
        n_mismatch++;
        $display("Error: test %s expected %0d actual %0d", test_name(tid), e, out_act);
      end
      if (lat != LATENCY) begin
        n_mismatch++;
        $display("Error: test %s latency expected %0d actual %0d", test_name(tid), LATENCY, lat);
      end
    end
  endtask

  ////////////////////////////////////////
  // monitor
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (rstn) begin
      if ($isunknown(out_valid)) begin
        n_protocol++;
        $display("out_valid is unknown after reset");
      end else if (out_valid) begin
        check_result();  // en_cnt still counts up to the edge that set out_valid
      end
      if (en) begin
        en_cnt++;
        if (in_valid) record_sample();
      end
    end
    mismatches    <= n_mismatch;
    protocol_errs <= n_protocol;
    pending       <= exp_q.size();
  end

endmodule

`default_nettype wire

/* conv_mac_top.sv */
// no back-pressure beyond en; in_bias is sampled only with in_first, results come 10 enabled edges later
`timescale 1ns/1ps
`default_nettype none

module conv_mac_top #(
  parameter int ACC_W = conv_pkg::ACC_W
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              en,
  input  logic              in_valid,
  input  logic              in_first,
  input  logic              in_last,
  input  conv_pkg::sample_t in_feat,
  input  conv_pkg::sample_t in_weight,
  input  conv_pkg::sample_t in_bias,
  output logic              out_valid,
  output conv_pkg::act_t    out_act
);

  // multiplier to accumulator
  logic              mult_valid, mult_first, mult_last;
  conv_pkg::sample_t mult_bias;
  conv_pkg::prod_t   mult_prod;

  // accumulator to requantizer
  logic                    sum_valid;
  logic signed [ACC_W-1:0] sum;

  signed_mult_pipe u_mult (
    .clk        (clk),
    .rstn       (rstn),
    .en         (en),
    .in_valid   (in_valid),
    .in_first   (in_first),
    .in_last    (in_last),
    .in_feat    (in_feat),
    .in_weight  (in_weight),
    .in_bias    (in_bias),
    .mult_valid (mult_valid),
    .mult_first (mult_first),
    .mult_last  (mult_last),
    .mult_bias  (mult_bias),
    .mult_prod  (mult_prod)
  );

  mac_accumulator #(.ACC_W(ACC_W)) u_acc (
    .clk        (clk),
    .rstn       (rstn),
    .en         (en),
    .mult_valid (mult_valid),
    .mult_first (mult_first),
    .mult_last  (mult_last),
    .mult_bias  (mult_bias),
    .mult_prod  (mult_prod),
    .sum_valid  (sum_valid),
    .sum        (sum)
  );

  requant_relu #(.ACC_W(ACC_W)) u_rq (
    .clk       (clk),
    .rstn      (rstn),
    .en        (en),
    .sum_valid (sum_valid),
    .sum       (sum),
    .out_valid (out_valid),
    .out_act   (out_act)
  );

endmodule

`default_nettype wire

/* requant_relu.sv */
// sum is read only with sum_valid; out_valid is a one-cycle pulse and drops whenever en is low
`timescale 1ns/1ps
`default_nettype none

module requant_relu #(
  parameter int ACC_W = conv_pkg::ACC_W
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    en,
  input  logic                    sum_valid,
  input  logic signed [ACC_W-1:0] sum,
  output logic                    out_valid,
  output conv_pkg::act_t          out_act
);

  localparam int SAT_LIM = (conv_pkg::OUT_MAX + 1) << conv_pkg::FRAC_BITS;  // 8192

  conv_pkg::act_t act_next;

  ////////////////////////////////////////
  // relu, saturate, drop fraction bits
  ////////////////////////////////////////
  always_comb begin
    if (sum[ACC_W-1]) begin
      act_next = '0;                                  // negative
    end else if (sum >= SAT_LIM) begin
      act_next = conv_pkg::DATA_W'(conv_pkg::OUT_MAX);
    end else begin
      act_next = {1'b0, sum[conv_pkg::FRAC_BITS +: conv_pkg::DATA_W-1]};  // bits 12..6
    end
  end

  always_ff @(posedge clk) begin
    if (en && sum_valid) out_act <= act_next;
  end

  always_ff @(posedge clk) begin
    if (!rstn) out_valid <= 1'b0;
    else       out_valid <= en & sum_valid;  // cleared on stalled edges so each result shows once
  end

  // a reported activation is known and in range
  a_act_in_range: assert property (@(posedge clk) disable iff (!rstn)
    out_valid |-> (!$isunknown(out_act) && (out_act <= conv_pkg::OUT_MAX)));

endmodule

`default_nettype wire

/* mac_accumulator.sv */
// one window at a time in order; ACC_W must hold PROD_W and the bias scaled by FRAC_BITS
`timescale 1ns/1ps
`default_nettype none

module mac_accumulator #(
  parameter int ACC_W = conv_pkg::ACC_W
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    en,
  input  logic                    mult_valid,
  input  logic                    mult_first,
  input  logic                    mult_last,
  input  conv_pkg::sample_t       mult_bias,
  input  conv_pkg::prod_t         mult_prod,
  output logic                    sum_valid,
  output logic signed [ACC_W-1:0] sum
);

  typedef logic signed [ACC_W-1:0] acc_t;

  acc_t prod_ext;   // product, sign extended
  acc_t bias_seed;  // bias in accumulator scale
  acc_t addend;
  acc_t add_sum;
  logic win_open;   // a window has started and not yet ended

  assign prod_ext  = {{(ACC_W - conv_pkg::PROD_W){mult_prod[conv_pkg::PROD_W-1]}}, mult_prod};
  assign bias_seed = {{(ACC_W - conv_pkg::DATA_W - conv_pkg::FRAC_BITS){mult_bias[conv_pkg::DATA_W-1]}},
                      mult_bias, {conv_pkg::FRAC_BITS{1'b0}}};
  assign addend    = mult_first ? bias_seed : sum;  // first sample restarts from the bias

  cla_adder #(.WIDTH(ACC_W)) u_add (
    .a    (prod_ext),
    .b    (addend),
    .c_in (1'b0),
    .sum  (add_sum)
  );

  always_ff @(posedge clk) begin
    if (en && mult_valid) sum <= add_sum;
  end

  ////////////////////////////////////////
  // window tracking
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      sum_valid <= 1'b0;
      win_open  <= 1'b0;
    end else if (en) begin
      sum_valid <= mult_valid & mult_last;
      if (mult_valid) win_open <= !mult_last;
    end
  end

  // after a last, the next product has to open a new window
  a_first_after_last: assert property (@(posedge clk) disable iff (!rstn)
    (en && mult_valid && !win_open) |-> mult_first);

endmodule

`default_nettype wire

/* signed_mult_pipe.sv */
// fixed 8x8 signed, latency 8 enabled edges; data stages are not reset, only the flags are
`timescale 1ns/1ps
`default_nettype none

module signed_mult_pipe (
  input  logic              clk,
  input  logic              rstn,
  input  logic              en,
  input  logic              in_valid,
  input  logic              in_first,
  input  logic              in_last,
  input  conv_pkg::sample_t in_feat,
  input  conv_pkg::sample_t in_weight,
  input  conv_pkg::sample_t in_bias,
  output logic              mult_valid,
  output logic              mult_first,
  output logic              mult_last,
  output conv_pkg::sample_t mult_bias,
  output conv_pkg::prod_t   mult_prod
);

  localparam int STAGES = 8;

  logic [7:0]        feat_mag, wgt_mag;
  logic [7:0]        pp [8];      // gated partial products
  logic [7:0]        pp_q [8];
  logic [STAGES-2:0] sign_q;      // result sign, stages 1..7
  logic [STAGES-1:0] vld_q, first_q, last_q;
  conv_pkg::sample_t bias_q [STAGES];

  logic [5:0]  lsb2 [4];
  logic [5:0]  lsb2_q [4];
  logic [2:0]  hia2_q [4];        // even product bits 7..5
  logic [3:0]  hib2_q [4];        // odd product bits 7..4
  logic [4:0]  msb3 [4];
  logic [9:0]  s3_q [4];
  logic [7:0]  lsb4 [2];
  logic [7:0]  lsb4_q [2];
  logic [2:0]  hia4_q [2];
  logic [4:0]  hib4_q [2];
  logic [4:0]  msb5 [2];
  logic [11:0] s5_q [2];
  logic [9:0]  lsb6, lsb6_q;
  logic [2:0]  hia6_q;
  logic [6:0]  hib6_q;
  logic [6:0]  msb7;
  logic [15:0] mag7_q;            // unsigned product

  ////////////////////////////////////////
  // stage 1 magnitudes, partial products
  ////////////////////////////////////////
  assign feat_mag = in_feat[7] ? (~in_feat) + 8'd1 : in_feat;  // -128 maps to 8'h80
  assign wgt_mag  = in_weight[7] ? (~in_weight) + 8'd1 : in_weight;

  always_comb begin
    for (int k = 0; k < 8; k++) pp[k] = wgt_mag[k] ? feat_mag : 8'd0;
  end

  ////////////////////////////////////////
  // adder tree, low part then high part
  ////////////////////////////////////////
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      lsb2[k] = {1'b0, pp_q[2*k][4:0]} + {1'b0, pp_q[2*k+1][3:0], 1'b0};
      msb3[k] = {2'b0, hia2_q[k]} + {1'b0, hib2_q[k]} + {4'b0, lsb2_q[k][5]};
    end
    for (int k = 0; k < 2; k++) begin
      lsb4[k] = {1'b0, s3_q[2*k][6:0]} + {1'b0, s3_q[2*k+1][4:0], 2'b0};
      msb5[k] = {2'b0, hia4_q[k]} + hib4_q[k] + {4'b0, lsb4_q[k][7]};  // fits, sum < 4096
    end
    lsb6 = {1'b0, s5_q[0][8:0]} + {1'b0, s5_q[1][4:0], 4'b0};
    msb7 = {4'b0, hia6_q} + hib6_q + {6'b0, lsb6_q[9]};
  end

  always_ff @(posedge clk) begin
    if (en) begin
      for (int k = 0; k < 8; k++) pp_q[k] <= pp[k];                // stage 1
      for (int k = 0; k < 4; k++) begin                             // stage 2
        lsb2_q[k] <= lsb2[k];
        hia2_q[k] <= pp_q[2*k][7:5];
        hib2_q[k] <= pp_q[2*k+1][7:4];
      end
      for (int k = 0; k < 4; k++) s3_q[k] <= {msb3[k], lsb2_q[k][4:0]};  // stage 3
      for (int k = 0; k < 2; k++) begin                             // stage 4
        lsb4_q[k] <= lsb4[k];
        hia4_q[k] <= s3_q[2*k][9:7];
        hib4_q[k] <= s3_q[2*k+1][9:5];
      end
      for (int k = 0; k < 2; k++) s5_q[k] <= {msb5[k], lsb4_q[k][6:0]};  // stage 5
      lsb6_q <= lsb6;                                               // stage 6
      hia6_q <= s5_q[0][11:9];
      hib6_q <= s5_q[1][11:5];
      mag7_q <= {msb7, lsb6_q[8:0]};                                // stage 7
      mult_prod <= sign_q[STAGES-2] ? (~mag7_q) + 16'd1 : mag7_q;   // stage 8 sign restore
      sign_q <= {sign_q[STAGES-3:0], in_feat[7] ^ in_weight[7]};
    end
  end

  ////////////////////////////////////////
  // sideband
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld_q   <= '0;
      first_q <= '0;
      last_q  <= '0;
    end else if (en) begin
      vld_q   <= {vld_q[STAGES-2:0], in_valid};
      first_q <= {first_q[STAGES-2:0], in_valid & in_first};  // flags only ride on valid slots
      last_q  <= {last_q[STAGES-2:0], in_valid & in_last};
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      bias_q[0] <= in_bias;
      for (int k = 1; k < STAGES; k++) bias_q[k] <= bias_q[k-1];
    end
  end

  assign mult_valid = vld_q[STAGES-1];
  assign mult_first = first_q[STAGES-1];
  assign mult_last  = last_q[STAGES-1];
  assign mult_bias  = bias_q[STAGES-1];

  // reset must have flushed the whole flag pipe before en is used
  a_flags_known: assert property (@(posedge clk) disable iff (!rstn)
    en |-> !$isunknown({mult_valid, mult_first, mult_last}));

endmodule

`default_nettype wire

/* cla_adder.sv */
// WIDTH must be a multiple of 4; wraps modulo 2**WIDTH with no carry or overflow output
`timescale 1ns/1ps
`default_nettype none

module cla_adder #(
  parameter int WIDTH = conv_pkg::ACC_W
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             c_in,
  output logic [WIDTH-1:0] sum
);

  localparam int NB = WIDTH / 4;  // number of 4-bit blocks

  logic [NB-1:0] p_blk;  // group propagate per block
  logic [NB-1:0] g_blk;  // group generate per block
  logic [NB-1:0] carry;  // carry into each block

  if (WIDTH % 4 != 0) begin : g_width_check
    $error("cla_adder: WIDTH %0d is not a multiple of 4", WIDTH);
  end

  ////////////////////////////////////////
  // lookahead carry unit
  ////////////////////////////////////////
  // each block carry is expanded from the group terms below it
  always_comb begin
    logic term;
    carry[0] = c_in;
    for (int i = 1; i < NB; i++) begin
      term = c_in;
      for (int j = 0; j < i; j++) begin
        term = g_blk[j] | (p_blk[j] & term);
      end
      carry[i] = term;
    end
  end

  for (genvar k = 0; k < NB; k++) begin : g_blk_inst
    cla4_block u_blk (
      .a     (a[4*k +: 4]),
      .b     (b[4*k +: 4]),
      .c_in  (carry[k]),
      .s     (sum[4*k +: 4]),
      .p_grp (p_blk[k]),
      .g_grp (g_blk[k])
    );
  end

endmodule

`default_nettype wire

/* cla4_block.sv */
// purely combinational 4-bit slice; no carry out, the caller rebuilds carries from p_grp/g_grp
`timescale 1ns/1ps
`default_nettype none

module cla4_block (
  input  logic [3:0] a,
  input  logic [3:0] b,
  input  logic       c_in,
  output logic [3:0] s,
  output logic       p_grp,
  output logic       g_grp
);

  logic [3:0] p;  // bit propagate
  logic [3:0] g;  // bit generate
  logic [2:0] c;  // carries into bits 1..3

  assign p = a ^ b;
  assign g = a & b;

  ////////////////////////////////////////
  // internal carries, two-level form
  ////////////////////////////////////////
  assign c[0] = g[0] | (p[0] & c_in);
  assign c[1] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c_in);
  assign c[2] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
              | (p[2] & p[1] & p[0] & c_in);

  assign s = p ^ {c, c_in};

  // group terms for the next lookahead level
  assign p_grp = &p;
  assign g_grp = g[3]
               | (p[3] & g[2])
               | (p[3] & p[2] & g[1])
               | (p[3] & p[2] & p[1] & g[0]);

endmodule

`default_nettype wire

/* conv_pkg.sv */
// shared widths and types; OUT_MAX and FRAC_BITS together fix the saturation point at 8192
`default_nettype none

package conv_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////
  localparam int DATA_W = 8;           // feature, weight and bias samples
  localparam int PROD_W = 2 * DATA_W;  // full product of two samples
  localparam int ACC_W  = 28;          // default window accumulator

  ////////////////////////////////////////
  // requantization
  ////////////////////////////////////////
  localparam int FRAC_BITS = 6;    // accumulator scale, bias enters shifted by this
  localparam int OUT_MAX   = 127;  // largest activation; sums of (OUT_MAX+1)<<FRAC_BITS saturate

  ////////////////////////////////////////
  // vector types
  ////////////////////////////////////////
  typedef logic signed [DATA_W-1:0] sample_t;  // signed feature, weight, bias
  typedef logic signed [PROD_W-1:0] prod_t;    // signed product
  typedef logic        [DATA_W-1:0] act_t;     // activation after relu, never negative

endpackage

`default_nettype wire
